// File: run_sim.sh
#!/bin/sh
# build and run the dcache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module dcache_tb -f vlog.f > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "verilator build returned an error"
  exit 1
fi

# assertion errors must not stop the run, the testbench reports them
./obj_dir/Vdcache_tb +verilator+error+limit+100 > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "simulation returned an error"
  exit 1
fi

if grep -q "^Test passed$" sim.log; then
  exit 0
fi
echo "pass line missing from sim.log"
exit 1

// File: source/bank_if.sv
`include "dcache_defines.svh"

`default_nettype none

// controller side of the data banks
interface bank_ctrl_if import dcache_pkg::*; ();
  index_t index;       // line being looked up or filled
  word_sel_t word_sel; // cpu word in the line
  word_sel_t beat;     // burst counter
  logic fill_we;       // one refill beat
  word_t fill_data;
  logic store_we;      // strobed store hit
  word_t store_data;
  strb_t store_strb;
  word_t hit_word;     // bank word at word_sel
  word_t wb_word;      // bank word at beat, victim data

  modport ctrl (output index, word_sel, beat, fill_we, fill_data,
                output store_we, store_data, store_strb, input hit_word, wb_word);
  modport steer (input index, word_sel, beat, fill_we, fill_data,
                 input store_we, store_data, store_strb);
  modport select (input word_sel, beat, output hit_word, wb_word);
endinterface

// per-bank wires
interface bank_array_if import dcache_pkg::*; ();
  index_t index;                  // shared by all banks
  logic we [`DCACHE_WORDS];
  word_t wdata [`DCACHE_WORDS];
  word_t rdata [`DCACHE_WORDS];   // async read

  modport feed (output index, we, wdata, input rdata);
  modport bank (input index, we, wdata, output rdata);
  modport drain (input rdata);
endinterface

`default_nettype wire

// File: source/bank_write_steer.sv
`include "dcache_defines.svh"

`default_nettype none

// routes refill beats and store hits to the one bank they touch
module bank_write_steer import dcache_pkg::*; (
  bank_ctrl_if.steer ctrl,
  bank_array_if.feed banks
);

  // byte merge of a store into the word already in the bank
  function automatic word_t merge_store(word_t old_word, word_t new_word, strb_t strb);
    word_t merged;
    merged = old_word;
    for (int i = 0; i < $bits(strb_t); i++) begin
      if (strb[i]) begin
        merged[8*i +: 8] = new_word[8*i +: 8];  // strobed byte wins
      end
    end
    return merged;
  endfunction

  assign banks.index = ctrl.index;  // all banks share the line

  always_comb begin
    for (int b = 0; b < `DCACHE_WORDS; b++) begin
      // refill picks the bank by beat, a store by address word
      banks.we[b] = (ctrl.fill_we && ctrl.beat == word_sel_t'(b)) ||
                    (ctrl.store_we && ctrl.word_sel == word_sel_t'(b));
      if (ctrl.fill_we) begin
        banks.wdata[b] = ctrl.fill_data;  // full word from the bus
      end else begin
        banks.wdata[b] = merge_store(banks.rdata[b], ctrl.store_data, ctrl.store_strb);
      end
    end
  end

endmodule

`default_nettype wire

// File: source/dcache_ctrl.sv
`include "dcache_defines.svh"

`default_nettype none

// lookup fsm, tag store and bus sequencing
module dcache_ctrl import dcache_pkg::*, mem_bus_pkg::*; (
  input  wire logic clk,
  input  wire logic rst,
  // cpu port
  input  word_t     cpu_addr_i,
  input  bus_size_t cpu_size_i,
  input  strb_t     cpu_strb_i,
  input  wire logic cpu_req_i,
  input  wire logic cpu_we_i,
  input  word_t     cpu_wdata_i,
  output word_t     cpu_rdata_o,
  output logic      cpu_ready_o,
  // bus read side
  output word_t     bus_araddr_o,
  output logic      bus_arvalid_o,
  output bus_size_t bus_arsize_o,
  output bus_len_t  bus_arlen_o,
  input  wire logic bus_rvalid_i,
  input  word_t     bus_rdata_i,
  // bus write side
  output word_t     bus_awaddr_o,
  output logic      bus_awvalid_o,
  output bus_size_t bus_awsize_o,
  output bus_len_t  bus_awlen_o,
  output strb_t     bus_wstrb_o,
  output word_t     bus_wdata_o,
  input  wire logic bus_wready_i,
  bank_ctrl_if.ctrl data
);

  typedef enum logic [2:0] {
    ST_RESET, ST_IDLE, ST_WRITE_BACK, ST_REFILL, ST_UNC_READ, ST_UNC_WRITE
  } state_t;

  state_t state;
  word_sel_t beat_q;    // burst counter
  logic ready_q;        // one-cycle done pulse
  logic arvalid_q;
  logic awvalid_q;
  word_t araddr_q;
  word_t awaddr_q;
  word_t unc_rdata_q;   // last uncached read, aligned
  word_t unc_aligned;
  word_t rdata_shift;
  tag_entry_t tag_rd;
  tag_entry_t tag_wdata;
  logic tag_we;

  // address split
  tag_t addr_tag;
  index_t addr_index;
  word_sel_t addr_word;
  assign addr_tag   = cpu_addr_i[`DCACHE_XLEN-1 -: `DCACHE_TAG_W];
  assign addr_index = cpu_addr_i[`DCACHE_OFFSET_W +: `DCACHE_INDEX_W];
  assign addr_word  = cpu_addr_i[2 +: $bits(word_sel_t)];

  logic uncached;
  logic hit;
  logic accept;
  logic store_hit;
  logic rd_beat;
  logic wr_beat;
  logic last_beat;
  assign uncached  = cpu_addr_i[`DCACHE_XLEN-1 -: 4] == `DCACHE_UNCACHE_NIBBLE;
  assign hit       = tag_rd.valid && tag_rd.tag == addr_tag;
  assign accept    = state == ST_IDLE && cpu_req_i && !ready_q;  // req ignored in ready cycle
  assign store_hit = accept && !uncached && hit && cpu_we_i;
  assign rd_beat   = arvalid_q && bus_rvalid_i;
  assign wr_beat   = awvalid_q && bus_wready_i;
  assign last_beat = beat_q == word_sel_t'(`DCACHE_BURST_LEN);

  // tag store, written on a store hit or the last refill beat
  assign tag_we    = store_hit || (state == ST_REFILL && rd_beat && last_beat);
  assign tag_wdata = '{valid: 1'b1, dirty: store_hit, tag: addr_tag};

  line_ram #(.entry_t(tag_entry_t)) u_tag_store (
    .clk     (clk),
    .rst     (rst),
    .addr_i  (addr_index),
    .we_i    (tag_we),
    .wdata_i (tag_wdata),
    .rdata_o (tag_rd)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= ST_RESET;
      beat_q    <= '0;
      ready_q   <= 1'b0;
      arvalid_q <= 1'b0;
      awvalid_q <= 1'b0;
    end else begin
      ready_q <= 1'b0;
      case (state)
        ST_RESET: state <= ST_IDLE;
        ST_IDLE: begin
          beat_q <= '0;
          if (accept && uncached) begin
            if (cpu_we_i) begin
              state     <= ST_UNC_WRITE;
              awvalid_q <= 1'b1;
            end else begin
              state     <= ST_UNC_READ;
              arvalid_q <= 1'b1;
            end
          end else if (accept && hit) begin
            ready_q <= 1'b1;  // read or write hit done next cycle
          end else if (accept && tag_rd.valid && tag_rd.dirty) begin
            state     <= ST_WRITE_BACK;  // victim goes out first
            awvalid_q <= 1'b1;
          end else if (accept) begin
            state     <= ST_REFILL;
            arvalid_q <= 1'b1;
          end
        end
        ST_WRITE_BACK: begin
          if (wr_beat && last_beat) begin
            awvalid_q <= 1'b0;
            arvalid_q <= 1'b1;  // straight into refill
            beat_q    <= '0;
            state     <= ST_REFILL;
          end else if (wr_beat) begin
            beat_q <= beat_q + 1'b1;
          end
        end
        ST_REFILL: begin
          if (rd_beat && last_beat) begin
            arvalid_q <= 1'b0;
            beat_q    <= '0;
            state     <= ST_IDLE;  // lookup retries as a hit
          end else if (rd_beat) begin
            beat_q <= beat_q + 1'b1;
          end
        end
        ST_UNC_READ: begin
          if (rd_beat) begin
            arvalid_q <= 1'b0;
            ready_q   <= 1'b1;
            state     <= ST_IDLE;
          end
        end
        ST_UNC_WRITE: begin
          if (wr_beat) begin
            awvalid_q <= 1'b0;
            ready_q   <= 1'b1;
            state     <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // bus addresses latched once per request
  always_ff @(posedge clk) begin
    if (accept) begin
      araddr_q <= uncached ? cpu_addr_i : {addr_tag, addr_index, {`DCACHE_OFFSET_W{1'b0}}};
      awaddr_q <= uncached ? cpu_addr_i : {tag_rd.tag, addr_index, {`DCACHE_OFFSET_W{1'b0}}};
    end
    if (state == ST_UNC_READ && rd_beat) begin
      unc_rdata_q <= unc_aligned;
    end
  end

  // uncached read data, zero-extended by size and offset
  assign rdata_shift = bus_rdata_i >> {cpu_addr_i[1:0], 3'b000};
  always_comb begin
    case (cpu_size_i)
      BUS_SIZE_BYTE: unc_aligned = {24'b0, rdata_shift[7:0]};
      BUS_SIZE_HALF: unc_aligned = {16'b0, rdata_shift[15:0]};
      default:       unc_aligned = bus_rdata_i;  // full word
    endcase
  end

  assign cpu_rdata_o = uncached ? unc_rdata_q : data.hit_word;
  assign cpu_ready_o = ready_q;

  // bank side
  assign data.index      = addr_index;
  assign data.word_sel   = addr_word;
  assign data.beat       = beat_q;
  assign data.fill_we    = state == ST_REFILL && rd_beat;
  assign data.fill_data  = bus_rdata_i;
  assign data.store_we   = store_hit;
  assign data.store_data = cpu_wdata_i;
  assign data.store_strb = cpu_strb_i;

  // bus outputs, burst vs single beat
  assign bus_araddr_o  = araddr_q;
  assign bus_arvalid_o = arvalid_q;
  assign bus_arsize_o  = (state == ST_UNC_READ) ? cpu_size_i : BUS_SIZE_WORD;
  assign bus_arlen_o   = (state == ST_UNC_READ) ? BUS_LEN_SINGLE : BUS_LEN_LINE;
  assign bus_awaddr_o  = awaddr_q;
  assign bus_awvalid_o = awvalid_q;
  assign bus_awsize_o  = (state == ST_UNC_WRITE) ? cpu_size_i : BUS_SIZE_WORD;
  assign bus_awlen_o   = (state == ST_UNC_WRITE) ? BUS_LEN_SINGLE : BUS_LEN_LINE;
  assign bus_wstrb_o   = (state == ST_UNC_WRITE) ? cpu_strb_i : '1;
  assign bus_wdata_o   = (state == ST_WRITE_BACK) ? data.wb_word : cpu_wdata_i;

endmodule

`default_nettype wire

// File: source/dcache_defines.svh
`ifndef DCACHE_DEFINES_SVH
`define DCACHE_DEFINES_SVH

// address and data width
`define DCACHE_XLEN 32

// address split: tag | index | offset
`define DCACHE_OFFSET_W 6   // 64-byte line
`define DCACHE_INDEX_W 7    // 128 lines
`define DCACHE_TAG_W 19     // what is left of the address

// one bank per word of a line
`define DCACHE_WORDS 16

// line burst, beats minus one
`define DCACHE_BURST_LEN 15

// top address nibble of the uncached window
`define DCACHE_UNCACHE_NIBBLE 4'hA

`endif

// File: source/dcache_pkg.sv
`include "dcache_defines.svh"

`default_nettype none

package dcache_pkg;

  // one data word on the cpu side and in every bank
  typedef logic [`DCACHE_XLEN-1:0] word_t;

  // one strobe bit per byte
  typedef logic [`DCACHE_XLEN/8-1:0] strb_t;

  typedef logic [`DCACHE_INDEX_W-1:0] index_t;  // line number
  typedef logic [`DCACHE_TAG_W-1:0] tag_t;

  // word within a line, also the burst beat number
  typedef logic [$clog2(`DCACHE_WORDS)-1:0] word_sel_t;

  // tag store entry, 21 bits
  typedef struct packed {
    logic valid;  // line holds data
    logic dirty;  // line differs from memory
    tag_t tag;
  } tag_entry_t;

endpackage

`default_nettype wire

// File: source/dcache_top.sv
`include "dcache_defines.svh"

`default_nettype none

module dcache_top import dcache_pkg::*, mem_bus_pkg::*; (
  input  wire logic clk,
  input  wire logic rst,
  // cpu load/store port
  input  word_t     cpu_addr_i,
  input  bus_size_t cpu_size_i,
  input  strb_t     cpu_strb_i,
  input  wire logic cpu_req_i,
  input  wire logic cpu_we_i,
  input  word_t     cpu_wdata_i,
  output word_t     cpu_rdata_o,
  output logic      cpu_ready_o,
  // memory bus, read
  output word_t     bus_araddr_o,
  output logic      bus_arvalid_o,
  output bus_size_t bus_arsize_o,
  output bus_len_t  bus_arlen_o,
  input  wire logic bus_rvalid_i,
  input  word_t     bus_rdata_i,
  // memory bus, write
  output word_t     bus_awaddr_o,
  output logic      bus_awvalid_o,
  output bus_size_t bus_awsize_o,
  output bus_len_t  bus_awlen_o,
  output strb_t     bus_wstrb_o,
  output word_t     bus_wdata_o,
  input  wire logic bus_wready_i
);

  bank_ctrl_if  ctrl_bus ();
  bank_array_if bank_bus ();

  dcache_ctrl u_ctrl (
    .clk           (clk),
    .rst           (rst),
    .cpu_addr_i    (cpu_addr_i),
    .cpu_size_i    (cpu_size_i),
    .cpu_strb_i    (cpu_strb_i),
    .cpu_req_i     (cpu_req_i),
    .cpu_we_i      (cpu_we_i),
    .cpu_wdata_i   (cpu_wdata_i),
    .cpu_rdata_o   (cpu_rdata_o),
    .cpu_ready_o   (cpu_ready_o),
    .bus_araddr_o  (bus_araddr_o),
    .bus_arvalid_o (bus_arvalid_o),
    .bus_arsize_o  (bus_arsize_o),
    .bus_arlen_o   (bus_arlen_o),
    .bus_rvalid_i  (bus_rvalid_i),
    .bus_rdata_i   (bus_rdata_i),
    .bus_awaddr_o  (bus_awaddr_o),
    .bus_awvalid_o (bus_awvalid_o),
    .bus_awsize_o  (bus_awsize_o),
    .bus_awlen_o   (bus_awlen_o),
    .bus_wstrb_o   (bus_wstrb_o),
    .bus_wdata_o   (bus_wdata_o),
    .bus_wready_i  (bus_wready_i),
    .data          (ctrl_bus.ctrl)
  );

  bank_write_steer u_steer (.ctrl(ctrl_bus.steer), .banks(bank_bus.feed));

  word_select u_select (.ctrl(ctrl_bus.select), .banks(bank_bus.drain));

  // one word bank per word of the line
  for (genvar g = 0; g < `DCACHE_WORDS; g++) begin : g_bank
    line_ram #(.entry_t(word_t)) u_bank (
      .clk     (clk),
      .rst     (rst),
      .addr_i  (bank_bus.index),
      .we_i    (bank_bus.we[g]),
      .wdata_i (bank_bus.wdata[g]),
      .rdata_o (bank_bus.rdata[g])
    );
  end

endmodule

`default_nettype wire

// File: source/line_ram.sv
`include "dcache_defines.svh"

`default_nettype none

// one entry per cache line, async read, write at the edge
module line_ram import dcache_pkg::*; #(
  parameter type entry_t = word_t
) (
  input  wire logic   clk,
  input  wire logic   rst,
  input  index_t      addr_i,
  input  wire logic   we_i,
  input  entry_t      wdata_i,
  output entry_t      rdata_o
);

  localparam int LINES = 1 << `DCACHE_INDEX_W;

  entry_t mem [LINES];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < LINES; i++) begin
        mem[i] <= '0;  // tags come up invalid and clean
      end
    end else if (we_i) begin
      mem[addr_i] <= wdata_i;
    end
  end

  assign rdata_o = mem[addr_i];  // same-cycle lookup

endmodule

`default_nettype wire

// File: source/mem_bus_pkg.sv
`include "dcache_defines.svh"

`default_nettype none

package mem_bus_pkg;

  // transfer size code, bytes per beat
  typedef logic [3:0] bus_size_t;

  // burst length, beats minus one
  typedef logic [7:0] bus_len_t;

  localparam bus_size_t BUS_SIZE_BYTE = 4'd1;
  localparam bus_size_t BUS_SIZE_HALF = 4'd2;
  localparam bus_size_t BUS_SIZE_WORD = 4'd4;

  // whole line, 16 beats
  localparam bus_len_t BUS_LEN_LINE = bus_len_t'(`DCACHE_BURST_LEN);
  // uncached access, one beat
  localparam bus_len_t BUS_LEN_SINGLE = 8'd0;

endpackage

`default_nettype wire

// File: source/word_select.sv
`include "dcache_defines.svh"

`default_nettype none

// drains the banks: cpu hit word and write-back word
module word_select import dcache_pkg::*; (
  bank_ctrl_if.select ctrl,
  bank_array_if.drain banks
);

  word_t hit_word;
  word_t wb_word;

  always_comb begin
    hit_word = '0;
    wb_word  = '0;
    for (int b = 0; b < `DCACHE_WORDS; b++) begin
      // word addressed by the cpu
      if (ctrl.word_sel == word_sel_t'(b)) begin
        hit_word = banks.rdata[b];
      end
      // victim word follows the burst counter directly
      if (ctrl.beat == word_sel_t'(b)) begin
        wb_word = banks.rdata[b];
      end
    end
  end

  assign ctrl.hit_word = hit_word;
  assign ctrl.wb_word  = wb_word;  // next word shows once beat moves on

endmodule

`default_nettype wire

// File: verif/dcache_properties.sv
`include "dcache_defines.svh"

`default_nettype none

// bus and cpu port rules, bound into dcache_top
module dcache_properties import dcache_pkg::*, mem_bus_pkg::*; (
  input wire logic clk,
  input wire logic rst,
  input wire logic ready_i,
  input wire logic arvalid_i,
  input wire logic rvalid_i,
  input word_t     araddr_i,
  input bus_len_t  arlen_i,
  input wire logic awvalid_i,
  input wire logic wready_i,
  input word_t     awaddr_i,
  input bus_len_t  awlen_i
);
  timeunit 1ns;
  timeprecision 100ps;

  logic violation = 1'b0;  // sticky, polled from the testbench top

  // only one direction active at a time
  a_one_valid: assert property (@(posedge clk) disable iff (rst) !(arvalid_i && awvalid_i))
    else begin
      violation = 1'b1;
      $error("read and write valid high in the same cycle");
    end

  // address held while the slave stalls
  a_ar_stable: assert property (@(posedge clk) disable iff (rst)
      arvalid_i && !rvalid_i |=> $stable(araddr_i))
    else begin
      violation = 1'b1;
      $error("read address moved during a stall");
    end

  a_aw_stable: assert property (@(posedge clk) disable iff (rst)
      awvalid_i && !wready_i |=> $stable(awaddr_i))
    else begin
      violation = 1'b1;
      $error("write address moved during a stall");
    end

  // ready is a single-cycle pulse
  a_ready_pulse: assert property (@(posedge clk) disable iff (rst) ready_i |=> !ready_i)
    else begin
      violation = 1'b1;
      $error("cpu ready high for two cycles");
    end

  // single beat inside the uncached window, line burst elsewhere
  a_ar_len: assert property (@(posedge clk) disable iff (rst)
      arvalid_i |-> arlen_i == ((araddr_i[`DCACHE_XLEN-1 -: 4] == `DCACHE_UNCACHE_NIBBLE) ?
                                BUS_LEN_SINGLE : BUS_LEN_LINE))
    else begin
      violation = 1'b1;
      $error("illegal read burst length");
    end

  a_aw_len: assert property (@(posedge clk) disable iff (rst)
      awvalid_i |-> awlen_i == ((awaddr_i[`DCACHE_XLEN-1 -: 4] == `DCACHE_UNCACHE_NIBBLE) ?
                                BUS_LEN_SINGLE : BUS_LEN_LINE))
    else begin
      violation = 1'b1;
      $error("illegal write burst length");
    end

endmodule

bind dcache_top dcache_properties u_props (
  .clk       (clk),
  .rst       (rst),
  .ready_i   (cpu_ready_o),
  .arvalid_i (bus_arvalid_o),
  .rvalid_i  (bus_rvalid_i),
  .araddr_i  (bus_araddr_o),
  .arlen_i   (bus_arlen_o),
  .awvalid_i (bus_awvalid_o),
  .wready_i  (bus_wready_i),
  .awaddr_i  (bus_awaddr_o),
  .awlen_i   (bus_awlen_o)
);

`default_nettype wire

// File: verif/dcache_tb.sv
`include "dcache_defines.svh"

`default_nettype none

module dcache_tb import dcache_pkg::*, mem_bus_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int ROW_COUNT   = 12;
  localparam int CYCLE_LIMIT = ROW_COUNT * 200;  // worst case two bursts with stalls per row
  localparam word_t UNC_ADDR = 32'hA000_0100;    // inside the uncached window
  localparam word_t UNC_DATA = 32'hCAFE_BABE;

  typedef struct {
    logic      we;
    word_t     addr;
    bus_size_t size;
    strb_t     strb;
    word_t     wdata;
    word_t     exp_rdata;   // reads only
    int        exp_reads;   // read bursts started by the row
    int        exp_wbeats;  // write beats sent by the row
    word_t     exp_awaddr;  // first write address
  } row_t;

  logic clk;
  logic rst;
  word_t cpu_addr;
  bus_size_t cpu_size;
  strb_t cpu_strb;
  logic cpu_req;
  logic cpu_we;
  word_t cpu_wdata;
  word_t cpu_rdata;
  logic cpu_ready;
  word_t bus_araddr;
  logic bus_arvalid;
  bus_size_t bus_arsize;
  bus_len_t bus_arlen;
  logic bus_rvalid;
  word_t bus_rdata;
  word_t bus_awaddr;
  logic bus_awvalid;
  bus_size_t bus_awsize;
  bus_len_t bus_awlen;
  strb_t bus_wstrb;
  word_t bus_wdata;
  logic bus_wready;

  // memory model state
  word_t mem_words [word_t];  // sparse, written words only
  integer seed = 68421;
  int stall_cnt = 0;
  int rd_cnt = 0;             // beat within the current read burst
  int wr_cnt = 0;
  int rd_bursts = 0;
  int wr_beats = 0;
  word_t last_ar_addr = '0;
  word_t last_aw_addr = '0;
  bus_len_t last_ar_len = '0;
  bus_len_t last_aw_len = '0;
  bus_size_t last_ar_size = '0;
  bus_size_t last_aw_size = '0;
  strb_t last_wstrb = '0;
  int cycles = 0;
  row_t rows [ROW_COUNT];

  tb_clock_gen u_clk_gen (.clk_o(clk), .rst_o(rst));

  dcache_top dut_i (
    .clk           (clk),
    .rst           (rst),
    .cpu_addr_i    (cpu_addr),
    .cpu_size_i    (cpu_size),
    .cpu_strb_i    (cpu_strb),
    .cpu_req_i     (cpu_req),
    .cpu_we_i      (cpu_we),
    .cpu_wdata_i   (cpu_wdata),
    .cpu_rdata_o   (cpu_rdata),
    .cpu_ready_o   (cpu_ready),
    .bus_araddr_o  (bus_araddr),
    .bus_arvalid_o (bus_arvalid),
    .bus_arsize_o  (bus_arsize),
    .bus_arlen_o   (bus_arlen),
    .bus_rvalid_i  (bus_rvalid),
    .bus_rdata_i   (bus_rdata),
    .bus_awaddr_o  (bus_awaddr),
    .bus_awvalid_o (bus_awvalid),
    .bus_awsize_o  (bus_awsize),
    .bus_awlen_o   (bus_awlen),
    .bus_wstrb_o   (bus_wstrb),
    .bus_wdata_o   (bus_wdata),
    .bus_wready_i  (bus_wready)
  );

  // untouched memory reads as the inverted word address
  function automatic word_t pattern(word_t a);
    return ~{a[`DCACHE_XLEN-1:2], 2'b00};
  endfunction

  function automatic word_t mem_read(word_t a);
    word_t wa;
    wa = {a[`DCACHE_XLEN-1:2], 2'b00};
    if (mem_words.exists(wa)) begin
      return mem_words[wa];
    end
    return pattern(wa);
  endfunction

  task automatic check_value(input string what, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("FAIL at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
      $display("Test failed");
      $fatal(1, "mismatch on %s", what);
    end
  endtask

  task automatic set_row(input int i, input logic we, input word_t addr, input bus_size_t size,
                         input strb_t strb, input word_t wdata, input word_t exp_rdata,
                         input int exp_reads, input int exp_wbeats, input word_t exp_awaddr);
    rows[i] = '{we, addr, size, strb, wdata, exp_rdata, exp_reads, exp_wbeats, exp_awaddr};
  endtask

  task automatic build_table();
    word_t merged;
    // low half from the store, high half from memory
    merged = (pattern(32'h0000_1048) & 32'hFFFF_0000) | (32'h1234_5678 & 32'h0000_FFFF);
    set_row(0, 1'b0, 32'h0000_1040, BUS_SIZE_WORD, 4'hF, '0, pattern(32'h0000_1040), 1, 0, '0);
    set_row(1, 1'b0, 32'h0000_1064, BUS_SIZE_WORD, 4'hF, '0, pattern(32'h0000_1064), 0, 0, '0);
    set_row(2, 1'b1, 32'h0000_1048, BUS_SIZE_WORD, 4'b0011, 32'h1234_5678, '0, 0, 0, '0);
    set_row(3, 1'b0, 32'h0000_1048, BUS_SIZE_WORD, 4'hF, '0, merged, 0, 0, '0);
    // same index, new tag, dirty victim goes out first
    set_row(4, 1'b0, 32'h0000_3040, BUS_SIZE_WORD, 4'hF, '0, pattern(32'h0000_3040), 1, 16,
            32'h0000_1040);
    set_row(5, 1'b0, 32'h0000_1048, BUS_SIZE_WORD, 4'hF, '0, merged, 1, 0, '0);
    // upper half only, the reads below touch bytes 2 and 3
    set_row(6, 1'b1, UNC_ADDR, BUS_SIZE_WORD, 4'b1100, UNC_DATA, '0, 0, 1, UNC_ADDR);
    set_row(7, 1'b0, UNC_ADDR + 32'd2, BUS_SIZE_BYTE, 4'b0100, '0, {24'h0, UNC_DATA[23:16]},
            1, 0, '0);
    set_row(8, 1'b0, UNC_ADDR + 32'd2, BUS_SIZE_HALF, 4'b1100, '0, {16'h0, UNC_DATA[31:16]},
            1, 0, '0);
    // write miss allocates, then the retried store hits
    set_row(9, 1'b1, 32'h0000_2488, BUS_SIZE_WORD, 4'hF, 32'h0BAD_F00D, '0, 1, 0, '0);
    set_row(10, 1'b0, 32'h0000_2488, BUS_SIZE_WORD, 4'hF, '0, 32'h0BAD_F00D, 0, 0, '0);
    set_row(11, 1'b0, 32'h0000_24BC, BUS_SIZE_WORD, 4'hF, '0, pattern(32'h0000_24BC), 0, 0, '0);
  endtask

  task automatic apply_row(input int r);
    int reads0;
    int wbeats0;
    word_t got;
    logic unc;
    reads0  = rd_bursts;
    wbeats0 = wr_beats;
    unc = rows[r].addr[`DCACHE_XLEN-1 -: 4] == `DCACHE_UNCACHE_NIBBLE;
    @(posedge clk);
    #1;
    cpu_addr  = rows[r].addr;
    cpu_size  = rows[r].size;
    cpu_strb  = rows[r].strb;
    cpu_we    = rows[r].we;
    cpu_wdata = rows[r].wdata;
    cpu_req   = 1'b1;
    do @(negedge clk); while (!cpu_ready);  // cycle monitor catches a hang
    got = cpu_rdata;
    @(posedge clk);
    #1;
    cpu_req = 1'b0;
    if (!rows[r].we) begin
      check_value($sformatf("row %0d read data", r), got, rows[r].exp_rdata);
    end
    check_value($sformatf("row %0d read bursts", r), word_t'(rd_bursts - reads0),
                word_t'(rows[r].exp_reads));
    check_value($sformatf("row %0d write beats", r), word_t'(wr_beats - wbeats0),
                word_t'(rows[r].exp_wbeats));
    if (rows[r].exp_reads > 0) begin
      // line aligned burst, or the plain address for a single beat
      check_value($sformatf("row %0d read address", r), last_ar_addr,
                  unc ? rows[r].addr : {rows[r].addr[`DCACHE_XLEN-1:6], 6'b0});
      check_value($sformatf("row %0d read length", r), word_t'(last_ar_len),
                  unc ? 32'd0 : 32'd15);
      check_value($sformatf("row %0d read size", r), word_t'(last_ar_size),
                  word_t'(unc ? rows[r].size : BUS_SIZE_WORD));
    end
    if (rows[r].exp_wbeats > 0) begin
      check_value($sformatf("row %0d write address", r), last_aw_addr, rows[r].exp_awaddr);
      check_value($sformatf("row %0d write length", r), word_t'(last_aw_len),
                  unc ? 32'd0 : 32'd15);
      check_value($sformatf("row %0d write size", r), word_t'(last_aw_size),
                  word_t'(unc ? rows[r].size : BUS_SIZE_WORD));
      if (unc) begin
        check_value($sformatf("row %0d write strobes", r), word_t'(last_wstrb),
                    word_t'(rows[r].strb));
      end
    end
  endtask

  // slave side, answers a fixed delay after the edge with random stalls
  always begin
    @(posedge clk);
    #1;
    bus_rvalid = 1'b0;
    bus_wready = 1'b0;
    if (stall_cnt > 0) begin
      stall_cnt = stall_cnt - 1;
    end else if (bus_arvalid) begin
      bus_rvalid = 1'b1;
      bus_rdata  = mem_read(bus_araddr + word_t'(rd_cnt * 4));
    end else if (bus_awvalid) begin
      bus_wready = 1'b1;
    end
  end

  // beat bookkeeping where all bus signals are settled
  always @(negedge clk) begin
    word_t wa;
    word_t merged;
    if (bus_rvalid && bus_arvalid) begin
      if (rd_cnt == 0) begin
        rd_bursts    = rd_bursts + 1;
        last_ar_addr = bus_araddr;
        last_ar_len  = bus_arlen;
        last_ar_size = bus_arsize;
      end
      rd_cnt    = (rd_cnt >= int'(bus_arlen)) ? 0 : rd_cnt + 1;
      stall_cnt = int'($unsigned($random(seed)) % 32'd4);
    end
    if (bus_wready && bus_awvalid) begin
      if (wr_cnt == 0) begin
        last_aw_addr = bus_awaddr;
        last_aw_len  = bus_awlen;
        last_aw_size = bus_awsize;
        last_wstrb   = bus_wstrb;
      end
      wa = {bus_awaddr[`DCACHE_XLEN-1:2], 2'b00} + word_t'(wr_cnt * 4);
      merged = mem_read(wa);
      for (int i = 0; i < 4; i++) begin
        if (bus_wstrb[i]) begin
          merged[8*i +: 8] = bus_wdata[8*i +: 8];
        end
      end
      mem_words[wa] = merged;
      wr_beats  = wr_beats + 1;
      wr_cnt    = (wr_cnt >= int'(bus_awlen)) ? 0 : wr_cnt + 1;
      stall_cnt = int'($unsigned($random(seed)) % 32'd4);
    end
  end

  // run limit and bound assertion flag
  always @(negedge clk) begin
    if (!rst) begin
      cycles = cycles + 1;
    end
    if (cycles > CYCLE_LIMIT) begin
      $display("timeout, no finish within %0d cycles", CYCLE_LIMIT);
      $display("Test failed");
      $fatal(1, "run limit reached");
    end else if (dut_i.u_props.violation) begin
      $display("a bus or cpu port assertion failed at %0t ns", $time);
      $display("Test failed");
      $fatal(1, "assertion failure");
    end
  end

  initial begin
    cpu_addr   = '0;
    cpu_size   = BUS_SIZE_WORD;
    cpu_strb   = '0;
    cpu_req    = 1'b0;
    cpu_we     = 1'b0;
    cpu_wdata  = '0;
    bus_rvalid = 1'b0;
    bus_rdata  = '0;
    bus_wready = 1'b0;
    build_table();
    @(negedge rst);
    repeat (2) @(negedge clk);  // reset state, then idle
    check_value("cpu_ready_o after reset", word_t'(cpu_ready), '0);
    check_value("bus_arvalid_o after reset", word_t'(bus_arvalid), '0);
    check_value("bus_awvalid_o after reset", word_t'(bus_awvalid), '0);
    for (int r = 0; r < ROW_COUNT; r++) begin
      apply_row(r);
    end
    @(negedge clk);
    if (dut_i.u_props.violation) begin
      $display("a bus or cpu port assertion failed during the run");
      $display("Test failed");
      $fatal(1, "assertion failure");
    end else begin
      $display("Test passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: verif/tb_clock_gen.sv
`default_nettype none

// 10 ns clock, reset held for the first 5 rising edges
module tb_clock_gen (
  output logic clk_o,
  output logic rst_o
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  initial begin
    rst_o = 1'b1;
    repeat (5) @(posedge clk_o);
    #1 rst_o = 1'b0;  // released like any other input
  end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+source
source/dcache_pkg.sv
source/mem_bus_pkg.sv
source/bank_if.sv
source/line_ram.sv
source/bank_write_steer.sv
source/word_select.sv
source/dcache_ctrl.sv
source/dcache_top.sv
verif/tb_clock_gen.sv
verif/dcache_properties.sv
verif/dcache_tb.sv
